// ==== Makefile ====
# Verilator build for the mirror-padding DMA engine testbench

VERILATOR ?= verilator
TOP       ?= tb_mpad_engine
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -j 0

BIN = $(OBJ_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run the simulation, fail unless it passes"
	@echo "  clean  remove build output"
	@echo "  help   show this list"

$(BIN): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

test: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; \
	echo "$$out" | grep -qx "All checks passed"

clean:
	rm -rf $(OBJ_DIR)

// ==== tb.f ====
verilog/mpad_pkg.sv
verilog/mpad_sync_fifo.sv
verilog/mpad_coord_walker.sv
verilog/mpad_read_master.sv
verilog/mpad_write_master.sv
verilog/mpad_engine_top.sv
tb/tb_axi_mem.sv
tb/tb_mpad_engine.sv

// ==== tb/tb_axi_mem.sv ====
/*
 * AXI slave memory model for the padding engine testbench.
 * Sparse word storage, random ready signals, random read latency.
 */
`timescale 1ns/10ps

module tb_axi_mem (
    input  logic        clk,
    input  logic        rst_n,
    input  logic [31:0] araddr_i,
    input  logic        arvalid_i,
    output logic        arready_o,
    output logic [31:0] rdata_o,
    output logic        rvalid_o,
    input  logic        rready_i,
    input  logic [31:0] awaddr_i,
    input  logic        awvalid_i,
    output logic        awready_o,
    input  logic [31:0] wdata_i,
    input  logic        wvalid_i,
    output logic        wready_o,
    output logic        bvalid_o,
    input  logic        bready_i
);

    logic [31:0] mem [logic [31:0]];
    logic [31:0] rd_addr_q [$];
    int          rd_due_q [$];   // Cycle at which each read may return
    int          cycle;
    int          seed;
    logic [31:0] rnd;
    logic [31:0] wr_addr, wr_data;
    logic        aw_have, w_have, b_pend;

    task automatic load_word(input logic [31:0] addr, input logic [31:0] data);
        mem[addr] = data;
    endtask

    function automatic logic [31:0] read_word(input logic [31:0] addr);
        if (mem.exists(addr)) return mem[addr];
        return 32'hdead_beef;  // Unwritten location
    endfunction

    initial begin
        seed      = 32'hd92a_d69c;
        cycle     = 0;
        arready_o = 1'b0;
        awready_o = 1'b0;
        wready_o  = 1'b0;
        rvalid_o  = 1'b0;
        bvalid_o  = 1'b0;
        rdata_o   = '0;
        aw_have   = 1'b0;
        w_have    = 1'b0;
        b_pend    = 1'b0;
    end

    // Handshakes as seen at the clock edge
    always @(posedge clk) begin
        cycle = cycle + 1;
        if (!rst_n) begin
            rd_addr_q.delete();
            rd_due_q.delete();
            aw_have = 1'b0;
            w_have  = 1'b0;
            b_pend  = 1'b0;
        end else begin
            if (arvalid_i && arready_o) begin
                rnd = $random(seed);
                rd_addr_q.push_back(araddr_i);
                rd_due_q.push_back(cycle + int'(rnd[1:0]));
            end
            if (rvalid_o && rready_i) begin
                void'(rd_addr_q.pop_front());
                void'(rd_due_q.pop_front());
            end
            if (awvalid_i && awready_o) begin
                wr_addr = awaddr_i;
                aw_have = 1'b1;
            end
            if (wvalid_i && wready_o) begin
                wr_data = wdata_i;
                w_have  = 1'b1;
            end
            if (bvalid_o && bready_i) b_pend = 1'b0;
            if (aw_have && w_have && !b_pend) begin
                mem[wr_addr] = wr_data;
                aw_have = 1'b0;
                w_have  = 1'b0;
                b_pend  = 1'b1;
            end
        end
    end

    // New responses and ready values between edges
    always @(negedge clk) begin
        rnd       = $random(seed);
        arready_o = rnd[0] | rnd[1];
        awready_o = rnd[2];
        wready_o  = rnd[3] | rnd[4];
        if (rd_addr_q.size() > 0 && rd_due_q[0] <= cycle) begin
            rvalid_o = 1'b1;
            rdata_o  = read_word(rd_addr_q[0]);
        end else begin
            rvalid_o = 1'b0;
        end
        bvalid_o = b_pend & (bvalid_o | rnd[5]);  // Held once raised
    end

endmodule

// ==== tb/tb_mpad_engine.sv ====
/*
 * Testbench for the mirror-padding DMA engine. Runs several matrix
 * sizes against a random-latency AXI memory and checks every write.
 */
`timescale 1ns/10ps

module tb_mpad_engine;

    localparam int N0 = 3;
    localparam int N1 = 5;
    localparam int N2 = 8;
    localparam int TIMEOUT = 40 * ((N0+2)**2 + (N1+2)**2 + (N2+2)**2) + 1000;

    logic        clk, rst_n, start, done;
    logic [31:0] src_addr, dst_addr;
    logic [5:0]  mat_width;
    logic [3:0]  awid, wid, arid, awlen, arlen;
    logic [2:0]  awsize, arsize;
    logic [1:0]  awburst, arburst;
    logic [31:0] awaddr, wdata, araddr, rdata;
    logic [3:0]  wstrb;
    logic        awvalid, awready, wvalid, wready, wlast, bvalid, bready;
    logic        arvalid, arready, rvalid, rready;

    int          cycles, data_errs, addr_errs, proto_errs;
    int          cur_n, b_cnt;
    logic [31:0] cur_src, cur_dst;
    logic        done_prev;
    bit          seen [0:4095];
    logic [31:0] aw_rec, w_rec;
    logic        ar_wait, aw_wait, w_wait;
    logic [31:0] ar_prev, aw_prev, w_prev;

    mpad_engine_top #(.FIFO_DEPTH(4)) dut (
        .clk(clk), .rst_n(rst_n),
        .src_addr_i(src_addr), .dst_addr_i(dst_addr), .mat_width_i(mat_width),
        .start_i(start), .done_o(done),
        .awid_o(awid), .awaddr_o(awaddr), .awlen_o(awlen), .awsize_o(awsize),
        .awburst_o(awburst), .awvalid_o(awvalid), .awready_i(awready),
        .wid_o(wid), .wdata_o(wdata), .wstrb_o(wstrb), .wlast_o(wlast),
        .wvalid_o(wvalid), .wready_i(wready),
        .bid_i(4'd0), .bresp_i(2'b00), .bvalid_i(bvalid), .bready_o(bready),
        .arid_o(arid), .araddr_o(araddr), .arlen_o(arlen), .arsize_o(arsize),
        .arburst_o(arburst), .arvalid_o(arvalid), .arready_i(arready),
        .rid_i(4'd0), .rdata_i(rdata), .rresp_i(2'b00), .rlast_i(1'b1),
        .rvalid_i(rvalid), .rready_o(rready)
    );

    tb_axi_mem mem_i (
        .clk(clk), .rst_n(rst_n),
        .araddr_i(araddr), .arvalid_i(arvalid), .arready_o(arready),
        .rdata_o(rdata), .rvalid_o(rvalid), .rready_i(rready),
        .awaddr_i(awaddr), .awvalid_i(awvalid), .awready_o(awready),
        .wdata_i(wdata), .wvalid_i(wvalid), .wready_o(wready),
        .bvalid_o(bvalid), .bready_i(bready)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Padded coordinate to source coordinate
    function automatic int mirror_index(input int k, input int n);
        if (k == 0) return 1;
        if (k == n + 1) return n - 2;
        return k - 1;
    endfunction

    task automatic compare_field(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        assert (got == exp) else begin
            proto_errs++;
            $display("[ERROR] %0t %s: expected %h, got %h", $time, name, exp, got);
        end
    endtask

    task automatic check_write(input logic [31:0] addr, input logic [31:0] data);
        int          side, idx;
        logic [31:0] off, exp;
        side = cur_n + 2;
        off  = addr - cur_dst;
        assert (addr >= cur_dst && off < 32'(4 * side * side) && off[1:0] == 2'b00) else begin
            addr_errs++;
            $display("[ERROR] %0t write to address %h outside the destination matrix",
                     $time, addr);
            return;
        end
        idx = int'(off >> 2);
        exp = cur_src + 32'(mirror_index(idx / side, cur_n) * cur_n
                            + mirror_index(idx % side, cur_n));
        assert (data == exp) else begin
            data_errs++;
            $display("[ERROR] %0t wdata_o at %h: expected %h, got %h", $time, addr, exp, data);
        end
        assert (!seen[idx]) else begin
            addr_errs++;
            $display("[ERROR] %0t address %h written more than once", $time, addr);
        end
        seen[idx] = 1'b1;
    endtask

    // Bus monitor
    always @(posedge clk) begin
        if (rst_n) begin
            assert (!ar_wait || (arvalid && araddr == ar_prev)) else begin
                proto_errs++;
                $display("[ERROR] %0t araddr_o changed or arvalid_o dropped before handshake",
                         $time);
            end
            assert (!aw_wait || (awvalid && awaddr == aw_prev)) else begin
                proto_errs++;
                $display("[ERROR] %0t awaddr_o changed or awvalid_o dropped before handshake",
                         $time);
            end
            assert (!w_wait || (wvalid && wdata == w_prev)) else begin
                proto_errs++;
                $display("[ERROR] %0t wdata_o changed or wvalid_o dropped before handshake",
                         $time);
            end
            ar_wait = arvalid & ~arready;
            aw_wait = awvalid & ~awready;
            w_wait  = wvalid & ~wready;
            ar_prev = araddr;
            aw_prev = awaddr;
            w_prev  = wdata;

            if (arvalid && arready) begin
                assert (araddr >= cur_src && araddr - cur_src < 32'(4 * cur_n * cur_n)
                        && araddr[1:0] == 2'b00) else begin
                    addr_errs++;
                    $display("[ERROR] %0t read from address %h outside the source matrix",
                             $time, araddr);
                end
                // Single-beat INCR word reads with ID 0
                compare_field("arid_o", 32'(arid), 32'h0);
                compare_field("arlen_o", 32'(arlen), 32'h0);
                compare_field("arsize_o", 32'(arsize), 32'h2);
                compare_field("arburst_o", 32'(arburst), 32'h1);
            end
            if (awvalid && awready) begin
                aw_rec = awaddr;
                compare_field("awid_o", 32'(awid), 32'h0);
                compare_field("awlen_o", 32'(awlen), 32'h0);
                compare_field("awsize_o", 32'(awsize), 32'h2);
                compare_field("awburst_o", 32'(awburst), 32'h1);
            end
            if (wvalid && wready) begin
                w_rec = wdata;
                compare_field("wid_o", 32'(wid), 32'h0);
                compare_field("wstrb_o", 32'(wstrb), 32'hf);  // All four bytes
                compare_field("wlast_o", 32'(wlast), 32'h1);
            end
            if (bvalid && bready) begin
                check_write(aw_rec, w_rec);
                b_cnt++;
            end
            if (done && !done_prev) begin
                assert (b_cnt == (cur_n + 2) ** 2) else begin
                    proto_errs++;
                    $display("[ERROR] %0t done_o rose after %0d of %0d writes", $time, b_cnt,
                             (cur_n + 2) ** 2);
                end
            end
            done_prev = done;
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > TIMEOUT) begin
            $display("Timeout: the runs did not finish within %0d cycles", TIMEOUT);
            $display("Checks failed");
            $finish;
        end
    end

    task automatic run_matrix(input int n, input logic [31:0] src, input logic [31:0] dst);
        int missing;
        for (int i = 0; i < n * n; i++) mem_i.load_word(src + 32'(4 * i), src + 32'(i));
        for (int i = 0; i < 4096; i++) seen[i] = 1'b0;
        cur_n   = n;
        cur_src = src;
        cur_dst = dst;
        b_cnt   = 0;
        @(negedge clk);
        src_addr  = src;
        dst_addr  = dst;
        mat_width = 6'(n);
        start     = 1'b1;
        @(negedge clk);
        assert (done == 1'b0) else begin
            proto_errs++;
            $display("[ERROR] %0t done_o: expected 0, got %b", $time, done);
        end
        start = 1'b0;
        while (!done) @(negedge clk);
        assert (b_cnt == (n + 2) ** 2) else begin
            proto_errs++;
            $display("[ERROR] %0t B handshakes: expected %0d, got %0d", $time,
                     (n + 2) ** 2, b_cnt);
        end
        missing = 0;
        for (int i = 0; i < (n + 2) ** 2; i++) if (!seen[i]) missing++;
        assert (missing == 0) else begin
            addr_errs++;
            $display("N=%0d run left %0d destination words unwritten", n, missing);
        end
        repeat (6) begin
            @(negedge clk);
            assert (done == 1'b1) else begin
                proto_errs++;
                $display("[ERROR] %0t done_o: expected 1, got %b", $time, done);
            end
        end
    endtask

    initial begin
        rst_n      = 1'b0;
        start      = 1'b0;
        src_addr   = '0;
        dst_addr   = '0;
        mat_width  = '0;
        cycles     = 0;
        data_errs  = 0;
        addr_errs  = 0;
        proto_errs = 0;
        done_prev  = 1'b1;
        ar_wait    = 1'b0;
        aw_wait    = 1'b0;
        w_wait     = 1'b0;
        cur_n      = 3;
        cur_src    = '0;
        cur_dst    = '0;
        b_cnt      = 0;
        repeat (3) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        // Idle state straight after reset
        compare_field("done_o", 32'(done), 32'h1);
        compare_field("arvalid_o", 32'(arvalid), 32'h0);
        compare_field("awvalid_o", 32'(awvalid), 32'h0);
        compare_field("wvalid_o", 32'(wvalid), 32'h0);
        compare_field("bready_o", 32'(bready), 32'h0);
        compare_field("rready_o", 32'(rready), 32'h1);

        run_matrix(N0, 32'h0000_1000, 32'h0010_0000);
        run_matrix(N1, 32'h0000_4000, 32'h0020_0400);
        run_matrix(N2, 32'h0000_8800, 32'h0030_0800);

        $display("Errors: data %0d, address %0d, protocol %0d", data_errs, addr_errs,
                 proto_errs);
        if (data_errs + addr_errs + proto_errs == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// ==== verilog/mpad_coord_walker.sv ====
/*
 * Coordinate walker. Steps through the padded output matrix in row-major
 * order, maps each word to its mirrored source word and owns start/done.
 */
`timescale 1ns/10ps

module mpad_coord_walker (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         start_i,
    input  logic [mpad_pkg::ADDR_W-1:0]  src_addr_i,
    input  logic [mpad_pkg::ADDR_W-1:0]  dst_addr_i,
    input  logic [mpad_pkg::MAT_W-1:0]   mat_width_i,
    input  logic                         wr_ack_i,
    output logic                         req_valid_o,
    input  logic                         req_ready_i,
    output logic [mpad_pkg::ADDR_W-1:0]  req_src_addr_o,
    output logic [mpad_pkg::ADDR_W-1:0]  req_dst_addr_o,
    output logic                         done_o
);

    localparam int AW = mpad_pkg::ADDR_W;
    localparam int MW = mpad_pkg::MAT_W;
    localparam int CW = 2 * MW;  // Holds (N+2)^2

    mpad_pkg::walk_state_e state_q;

    logic [AW-1:0] src_base_q, dst_base_q;
    logic [MW-1:0] width_q;
    logic [MW-1:0] row_q, col_q;
    logic [CW-1:0] ack_cnt_q;
    logic          done_q;

    logic [MW-1:0] last_idx, side;
    logic [MW-1:0] src_row, src_col;
    logic [CW-1:0] total, ack_next;
    logic [AW-1:0] src_idx, dst_idx;
    logic          req_hs;

    // Maps a 0-based output index to its source index
    function automatic logic [MW-1:0] mirror(input logic [MW-1:0] k, input logic [MW-1:0] n);
        logic [MW-1:0] m;
        if (k == '0) begin
            m = MW'(1);
        end else if (k == n + MW'(1)) begin
            m = n - MW'(2);
        end else begin
            m = k - MW'(1);
        end
        return m;
    endfunction

    assign last_idx = width_q + MW'(1);
    assign side     = width_q + MW'(2);
    assign total    = CW'(side) * CW'(side);
    assign ack_next = ack_cnt_q + CW'(1);

    assign src_row = mirror(row_q, width_q);
    assign src_col = mirror(col_q, width_q);
    assign src_idx = AW'(src_row) * AW'(width_q) + AW'(src_col);
    assign dst_idx = AW'(row_q) * AW'(side) + AW'(col_q);

    assign req_valid_o    = (state_q == mpad_pkg::WALK_ISSUE);
    assign req_src_addr_o = src_base_q + src_idx * AW'(mpad_pkg::WORD_BYTES);
    assign req_dst_addr_o = dst_base_q + dst_idx * AW'(mpad_pkg::WORD_BYTES);
    assign req_hs         = req_valid_o & req_ready_i;
    assign done_o         = done_q;

    // Run configuration latched on start
    always_ff @(posedge clk) begin
        if (state_q == mpad_pkg::WALK_IDLE && start_i) begin
            src_base_q <= src_addr_i;
            dst_base_q <= dst_addr_i;
            width_q    <= mat_width_i;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q   <= mpad_pkg::WALK_IDLE;
            row_q     <= '0;
            col_q     <= '0;
            ack_cnt_q <= '0;
            done_q    <= 1'b1;
        end else begin
            if (wr_ack_i) ack_cnt_q <= ack_next;

            case (state_q)
                mpad_pkg::WALK_IDLE: begin
                    if (start_i) begin
                        row_q     <= '0;
                        col_q     <= '0;
                        ack_cnt_q <= '0;
                        done_q    <= 1'b0;
                        state_q   <= mpad_pkg::WALK_ISSUE;
                    end
                end
                mpad_pkg::WALK_ISSUE: begin
                    if (req_hs) begin
                        if (col_q == last_idx) begin
                            col_q <= '0;
                            if (row_q == last_idx) state_q <= mpad_pkg::WALK_DRAIN;
                            else row_q <= row_q + MW'(1);
                        end else begin
                            col_q <= col_q + MW'(1);
                        end
                    end
                end
                mpad_pkg::WALK_DRAIN: begin
                    // Final B handshake closes the run
                    if (wr_ack_i && ack_next == total) begin
                        done_q  <= 1'b1;
                        state_q <= mpad_pkg::WALK_DONE;
                    end
                end
                default: begin
                    if (!start_i) state_q <= mpad_pkg::WALK_IDLE;  // Start must be seen low
                end
            endcase
        end
    end

endmodule

// ==== verilog/mpad_engine_top.sv ====
/*
 * Mirror-padding DMA engine top level. Reads an NxN matrix over AXI and
 * writes the (N+2)x(N+2) mirror-padded result back.
 */
`timescale 1ns/10ps

module mpad_engine_top #(
    parameter int FIFO_DEPTH = 4
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic [mpad_pkg::ADDR_W-1:0]   src_addr_i,
    input  logic [mpad_pkg::ADDR_W-1:0]   dst_addr_i,
    input  logic [mpad_pkg::MAT_W-1:0]    mat_width_i,
    input  logic                          start_i,
    output logic                          done_o,
    // AW channel
    output logic [mpad_pkg::ID_W-1:0]     awid_o,
    output logic [mpad_pkg::ADDR_W-1:0]   awaddr_o,
    output logic [3:0]                    awlen_o,
    output logic [2:0]                    awsize_o,
    output logic [1:0]                    awburst_o,
    output logic                          awvalid_o,
    input  logic                          awready_i,
    // W channel
    output logic [mpad_pkg::ID_W-1:0]     wid_o,
    output logic [mpad_pkg::DATA_W-1:0]   wdata_o,
    output logic [mpad_pkg::DATA_W/8-1:0] wstrb_o,
    output logic                          wlast_o,
    output logic                          wvalid_o,
    input  logic                          wready_i,
    // B channel, response code ignored
    input  logic [mpad_pkg::ID_W-1:0]     bid_i,
    input  logic [1:0]                    bresp_i,
    input  logic                          bvalid_i,
    output logic                          bready_o,
    // AR channel
    output logic [mpad_pkg::ID_W-1:0]     arid_o,
    output logic [mpad_pkg::ADDR_W-1:0]   araddr_o,
    output logic [3:0]                    arlen_o,
    output logic [2:0]                    arsize_o,
    output logic [1:0]                    arburst_o,
    output logic                          arvalid_o,
    input  logic                          arready_i,
    // R channel, single beat so rlast and rresp are not needed
    input  logic [mpad_pkg::ID_W-1:0]     rid_i,
    input  logic [mpad_pkg::DATA_W-1:0]   rdata_i,
    input  logic [1:0]                    rresp_i,
    input  logic                          rlast_i,
    input  logic                          rvalid_i,
    output logic                          rready_o
);

    logic                        req_valid, req_ready;
    logic [mpad_pkg::ADDR_W-1:0] req_src_addr, req_dst_addr;
    logic                        tag_push, data_push, pop, wr_ack;
    logic                        tag_empty, data_empty;
    logic [mpad_pkg::ADDR_W-1:0] tag_in, tag_out;
    logic [mpad_pkg::DATA_W-1:0] data_in, data_out;

    // Fixed single-beat word transfers, ID 0
    assign awid_o    = '0;
    assign awlen_o   = mpad_pkg::AXI_LEN_SINGLE;
    assign awsize_o  = mpad_pkg::AXI_SIZE_4B;
    assign awburst_o = mpad_pkg::AXI_BURST_INCR;
    assign wid_o     = '0;
    assign wstrb_o   = '1;   // Full word
    assign wlast_o   = 1'b1;
    assign arid_o    = '0;
    assign arlen_o   = mpad_pkg::AXI_LEN_SINGLE;
    assign arsize_o  = mpad_pkg::AXI_SIZE_4B;
    assign arburst_o = mpad_pkg::AXI_BURST_INCR;

    mpad_coord_walker u_walker (
        .clk(clk), .rst_n(rst_n),
        .start_i(start_i), .src_addr_i(src_addr_i), .dst_addr_i(dst_addr_i),
        .mat_width_i(mat_width_i), .wr_ack_i(wr_ack),
        .req_valid_o(req_valid), .req_ready_i(req_ready),
        .req_src_addr_o(req_src_addr), .req_dst_addr_o(req_dst_addr),
        .done_o(done_o)
    );

    mpad_read_master #(.FIFO_DEPTH(FIFO_DEPTH)) u_rd (
        .clk(clk), .rst_n(rst_n),
        .req_valid_i(req_valid), .req_src_addr_i(req_src_addr),
        .req_dst_addr_i(req_dst_addr), .req_ready_o(req_ready),
        .araddr_o(araddr_o), .arvalid_o(arvalid_o), .arready_i(arready_i),
        .rdata_i(rdata_i), .rvalid_i(rvalid_i), .rready_o(rready_o),
        .tag_push_o(tag_push), .tag_data_o(tag_in),
        .data_push_o(data_push), .data_o(data_in), .data_pop_i(pop)
    );

    // Destination addresses in AR order
    mpad_sync_fifo #(.DEPTH(FIFO_DEPTH), .WIDTH(mpad_pkg::ADDR_W)) tag_fifo (
        .clk(clk), .rst_n(rst_n),
        .push_i(tag_push), .push_data_i(tag_in),
        .pop_i(pop), .pop_data_o(tag_out),
        .empty_o(tag_empty), .full_o()
    );

    // Read words, same order as the tags
    mpad_sync_fifo #(.DEPTH(FIFO_DEPTH), .WIDTH(mpad_pkg::DATA_W)) data_fifo (
        .clk(clk), .rst_n(rst_n),
        .push_i(data_push), .push_data_i(data_in),
        .pop_i(pop), .pop_data_o(data_out),
        .empty_o(data_empty), .full_o()
    );

    mpad_write_master u_wr (
        .clk(clk), .rst_n(rst_n),
        .tag_empty_i(tag_empty), .tag_addr_i(tag_out),
        .data_empty_i(data_empty), .data_i(data_out), .pop_o(pop),
        .awaddr_o(awaddr_o), .awvalid_o(awvalid_o), .awready_i(awready_i),
        .wdata_o(wdata_o), .wvalid_o(wvalid_o), .wready_i(wready_i),
        .bvalid_i(bvalid_i), .bready_o(bready_o), .wr_ack_o(wr_ack)
    );

endmodule

// ==== verilog/mpad_pkg.sv ====
/*
 * Mirror-padding DMA engine shared definitions
 * Bus widths, fixed AXI field codes and the coordinate walker states
 */
package mpad_pkg;

    // Bus and field widths
    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    localparam int MAT_W  = 6;   // Matrix size and coordinates, N+2 fits
    localparam int ID_W   = 4;

    // Fixed AXI attributes, single-beat word transfers only
    localparam logic [2:0] AXI_SIZE_4B    = 3'b010;
    localparam logic [1:0] AXI_BURST_INCR = 2'b01;
    localparam logic [3:0] AXI_LEN_SINGLE = 4'd0;

    // Address step between neighbouring words
    localparam int unsigned WORD_BYTES = 4;

    // Coordinate walker FSM
    typedef enum logic [1:0] {
        WALK_IDLE  = 2'd0,  // Waiting for start
        WALK_ISSUE = 2'd1,  // Handing out read requests
        WALK_DRAIN = 2'd2,  // All requests out, waiting on write acks
        WALK_DONE  = 2'd3   // Run finished, waits for start to drop
    } walk_state_e;

endpackage

// ==== verilog/mpad_read_master.sv ====
/*
 * Read master. Turns walker requests into single-beat AR transfers,
 * limits reads in flight and feeds the tag and data queues.
 */
`timescale 1ns/10ps

module mpad_read_master #(
    parameter int FIFO_DEPTH = 4
) (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         req_valid_i,
    input  logic [mpad_pkg::ADDR_W-1:0]  req_src_addr_i,
    input  logic [mpad_pkg::ADDR_W-1:0]  req_dst_addr_i,
    output logic                         req_ready_o,
    output logic [mpad_pkg::ADDR_W-1:0]  araddr_o,
    output logic                         arvalid_o,
    input  logic                         arready_i,
    input  logic [mpad_pkg::DATA_W-1:0]  rdata_i,
    input  logic                         rvalid_i,
    output logic                         rready_o,
    output logic                         tag_push_o,
    output logic [mpad_pkg::ADDR_W-1:0]  tag_data_o,
    output logic                         data_push_o,
    output logic [mpad_pkg::DATA_W-1:0]  data_o,
    input  logic                         data_pop_i
);

    localparam int CW = $clog2(FIFO_DEPTH) + 1;

    logic                        arvalid_q;
    logic [mpad_pkg::ADDR_W-1:0] araddr_q;
    logic [mpad_pkg::ADDR_W-1:0] tag_q;     // Destination of the pending AR
    logic [CW-1:0]               out_cnt_q; // Reads issued but not yet consumed
    logic                        req_hs, ar_hs;

    // One request slot, and never more reads out than the data queue holds
    assign req_ready_o = ~arvalid_q & (out_cnt_q < CW'(FIFO_DEPTH));
    assign req_hs      = req_valid_i & req_ready_o;
    assign ar_hs       = arvalid_q & arready_i;

    assign arvalid_o = arvalid_q;
    assign araddr_o  = araddr_q;

    // Data queue always has room thanks to the outstanding limit
    assign rready_o    = 1'b1;
    assign data_push_o = rvalid_i & rready_o;
    assign data_o      = rdata_i;

    assign tag_push_o = ar_hs;
    assign tag_data_o = tag_q;

    always_ff @(posedge clk) begin
        if (req_hs) begin
            araddr_q <= req_src_addr_i;
            tag_q    <= req_dst_addr_i;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            arvalid_q <= 1'b0;
            out_cnt_q <= '0;
        end else begin
            if (req_hs) arvalid_q <= 1'b1;
            else if (ar_hs) arvalid_q <= 1'b0;

            case ({ar_hs, data_pop_i})
                2'b10:   out_cnt_q <= out_cnt_q + CW'(1);
                2'b01:   out_cnt_q <= out_cnt_q - CW'(1);
                default: out_cnt_q <= out_cnt_q;  // None or both
            endcase
        end
    end

endmodule

// ==== verilog/mpad_sync_fifo.sv ====
/*
 * Synchronous FIFO, circular buffer with a fill count.
 * DEPTH must be a power of two.
 */
`timescale 1ns/10ps

module mpad_sync_fifo #(
    parameter int DEPTH = 4,
    parameter int WIDTH = 32
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             push_i,
    input  logic [WIDTH-1:0] push_data_i,
    input  logic             pop_i,
    output logic [WIDTH-1:0] pop_data_o,
    output logic             empty_o,
    output logic             full_o
);

    localparam int PW = $clog2(DEPTH);

    logic [WIDTH-1:0] mem [DEPTH];
    logic [PW-1:0]    wr_ptr_q, rd_ptr_q;   // Wrap on their own
    logic [PW:0]      count_q;
    logic             do_push, do_pop;

    assign empty_o    = (count_q == '0);
    assign full_o     = (count_q == (PW+1)'(DEPTH));
    assign do_push    = push_i & ~full_o;
    assign do_pop     = pop_i & ~empty_o;
    assign pop_data_o = mem[rd_ptr_q];

    always_ff @(posedge clk) begin
        if (do_push) mem[wr_ptr_q] <= push_data_i;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (do_push) wr_ptr_q <= wr_ptr_q + PW'(1);
            if (do_pop) rd_ptr_q <= rd_ptr_q + PW'(1);

            if (do_push && !do_pop) count_q <= count_q + (PW+1)'(1);
            else if (do_pop && !do_push) count_q <= count_q - (PW+1)'(1);
        end
    end

endmodule

// ==== verilog/mpad_write_master.sv ====
/*
 * Write master. Takes a destination tag and its word from the queue heads
 * and runs one AW/W/B transaction at a time.
 */
`timescale 1ns/10ps

module mpad_write_master (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         tag_empty_i,
    input  logic [mpad_pkg::ADDR_W-1:0]  tag_addr_i,
    input  logic                         data_empty_i,
    input  logic [mpad_pkg::DATA_W-1:0]  data_i,
    output logic                         pop_o,
    output logic [mpad_pkg::ADDR_W-1:0]  awaddr_o,
    output logic                         awvalid_o,
    input  logic                         awready_i,
    output logic [mpad_pkg::DATA_W-1:0]  wdata_o,
    output logic                         wvalid_o,
    input  logic                         wready_i,
    input  logic                         bvalid_i,
    output logic                         bready_o,
    output logic                         wr_ack_o
);

    logic busy_q;      // Transaction open until its B response
    logic awvalid_q;
    logic wvalid_q;
    logic start;
    logic aw_hs, w_hs, b_hs;

    assign start = ~busy_q & ~tag_empty_i & ~data_empty_i;
    assign aw_hs = awvalid_q & awready_i;
    assign w_hs  = wvalid_q & wready_i;
    assign b_hs  = bvalid_i & bready_o;

    // Queue heads stay put until the pop at B, so they drive the bus directly
    assign awaddr_o  = tag_addr_i;
    assign wdata_o   = data_i;
    assign awvalid_o = awvalid_q;
    assign wvalid_o  = wvalid_q;

    // Response accepted once both address and data have gone out
    assign bready_o = busy_q & ~awvalid_q & ~wvalid_q;

    assign pop_o    = b_hs;
    assign wr_ack_o = b_hs;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy_q    <= 1'b0;
            awvalid_q <= 1'b0;
            wvalid_q  <= 1'b0;
        end else begin
            if (start) begin
                busy_q    <= 1'b1;
                awvalid_q <= 1'b1;
                wvalid_q  <= 1'b1;
            end else begin
                // AW and W finish independently
                if (aw_hs) awvalid_q <= 1'b0;
                if (w_hs) wvalid_q <= 1'b0;
                if (b_hs) busy_q <= 1'b0;
            end
        end
    end

endmodule
